// File: hps_pkg.sv
package hps_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	// Screen dimension and window edge
	localparam int dim_w = 12;

	// Aspect value, top bit selects direct size
	localparam int ar_w = 13;

	// Host word
	localparam int io_w = 16;

	// Board LEDs
	localparam int led_w = 8;

	////////////////////////////////////////////////////////////////////////////
	// Reset defaults

	// 1920x1080 output until the host says otherwise
	localparam logic [dim_w-1:0] default_width  = 12'd1920;
	localparam logic [dim_w-1:0] default_height = 12'd1080;

	////////////////////////////////////////////////////////////////////////////
	// Host command opcodes

	typedef enum logic [7:0] {
		cmd_video_timing = 8'h20,
		cmd_led          = 8'h25,
		cmd_vset         = 8'h27,
		cmd_hset         = 8'h37,
		cmd_custom_ar    = 8'h3A
	} cmd_e;

endpackage

// File: hps_cmd_decoder.sv
`timescale 1ns/1ps

module hps_cmd_decoder import hps_pkg::*; (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_io_uio,
	input  logic             i_io_clk,
	input  logic [io_w-1:0]  i_io_din,
	input  logic [led_w-1:0] i_led_status,
	output logic [led_w-1:0] o_led,
	output logic [dim_w-1:0] o_width,
	output logic [dim_w-1:0] o_height,
	output logic [dim_w-1:0] o_vset,
	output logic [dim_w-1:0] o_hset,
	output logic             o_freescale,
	output logic [ar_w-1:0]  o_arc1x,
	output logic [ar_w-1:0]  o_arc1y,
	output logic [ar_w-1:0]  o_arc2x,
	output logic [ar_w-1:0]  o_arc2y
);

	logic             io_clk_s;
	logic             io_clk_q;
	logic             io_word;
	logic             has_cmd;
	cmd_e             cmd;
	logic [7:0]       cnt;
	logic [led_w-1:0] led_mask;
	logic [led_w-1:0] led_state;

	// Rising edge of the sampled strobe carries one word
	assign io_word = io_clk_s & ~io_clk_q;

	// Override bits where the mask is set, board status elsewhere
	assign o_led = (led_mask & led_state) | (~led_mask & i_led_status);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_s <= 1'b0;
			io_clk_q <= 1'b0;
		end else begin
			io_clk_s <= i_io_clk;
			io_clk_q <= io_clk_s;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd     <= 1'b0;
			cnt         <= '0;
			led_mask    <= '0;
			led_state   <= '0;
			o_width     <= default_width;
			o_height    <= default_height;
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (!i_io_uio) begin
			// Frame closed
			has_cmd <= 1'b0;
			cnt     <= '0;
		end else if (io_word) begin
			if (!has_cmd) begin
				// First word of the frame is the opcode
				has_cmd <= 1'b1;
				cmd     <= cmd_e'(i_io_din[7:0]);
				cnt     <= '0;
			end else begin
				if (cnt != '1)
					cnt <= cnt + 1'b1;
				case (cmd)
					cmd_video_timing: begin
						// Only active width and height are kept
						if (cnt == 8'd0)
							o_width <= i_io_din[dim_w-1:0];
						if (cnt == 8'd4)
							o_height <= i_io_din[dim_w-1:0];
					end
					cmd_led: begin
						led_mask  <= i_io_din[2*led_w-1:led_w];
						led_state <= i_io_din[led_w-1:0];
					end
					cmd_vset: o_vset <= i_io_din[dim_w-1:0];
					cmd_hset: begin
						o_freescale <= i_io_din[io_w-1];
						o_hset      <= i_io_din[dim_w-1:0];
					end
					cmd_custom_ar: begin
						case (cnt)
							8'd0: o_arc1x <= i_io_din[ar_w-1:0];
							8'd1: o_arc1y <= i_io_din[ar_w-1:0];
							8'd2: o_arc2x <= i_io_din[ar_w-1:0];
							8'd3: o_arc2y <= i_io_din[ar_w-1:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: ar_muldiv.sv
`timescale 1ns/1ps

module ar_muldiv import hps_pkg::*; (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_start,
	input  logic [dim_w-1:0] i_mul1,
	input  logic [dim_w-1:0] i_mul2,
	input  logic [dim_w-1:0] i_div,
	output logic             o_busy,
	output logic [dim_w-1:0] o_result
);

	localparam int prod_w = 2 * dim_w;
	localparam int cnt_w  = $clog2(prod_w + 1);

	logic [prod_w-1:0] quo;
	logic [dim_w-1:0]  rem;
	logic [dim_w-1:0]  div_r;
	logic [dim_w:0]    rem_sh;
	logic [dim_w:0]    rem_sub;
	logic [cnt_w-1:0]  bit_cnt;

	// Next dividend bit shifted into the partial remainder
	assign rem_sh  = {rem, quo[prod_w-1]};
	assign rem_sub = rem_sh - {1'b0, div_r};

	// Truncated quotient, low bits only
	assign o_result = quo[dim_w-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy  <= 1'b0;
			bit_cnt <= '0;
		end else if (i_start) begin
			o_busy  <= 1'b1;
			bit_cnt <= cnt_w'(prod_w);
		end else if (o_busy) begin
			bit_cnt <= bit_cnt - 1'b1;
			if (bit_cnt == cnt_w'(1))
				o_busy <= 1'b0;
		end
	end

	// Product on start, then one quotient bit per cycle
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo   <= i_mul1 * i_mul2;
			div_r <= i_div;
			rem   <= '0;
		end else if (o_busy) begin
			if (rem_sh >= {1'b0, div_r}) begin
				rem <= rem_sub[dim_w-1:0];
				quo <= {quo[prod_w-2:0], 1'b1};
			end else begin
				rem <= rem_sh[dim_w-1:0];
				quo <= {quo[prod_w-2:0], 1'b0};
			end
		end
	end

endmodule

// File: video_window_calc.sv
`timescale 1ns/1ps

module video_window_calc import hps_pkg::*; (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic [dim_w-1:0] i_width,
	input  logic [dim_w-1:0] i_height,
	input  logic [dim_w-1:0] i_vset,
	input  logic [dim_w-1:0] i_hset,
	input  logic             i_freescale,
	input  logic [ar_w-1:0]  i_arx,
	input  logic [ar_w-1:0]  i_ary,
	input  logic [ar_w-1:0]  i_arc1x,
	input  logic [ar_w-1:0]  i_arc1y,
	input  logic [ar_w-1:0]  i_arc2x,
	input  logic [ar_w-1:0]  i_arc2y,
	output logic [dim_w-1:0] o_hmin,
	output logic [dim_w-1:0] o_hmax,
	output logic [dim_w-1:0] o_vmin,
	output logic [dim_w-1:0] o_vmax
);

	logic [dim_w-1:0] hdmi_width;
	logic [dim_w-1:0] hdmi_height;
	logic [dim_w-1:0] arx;
	logic [dim_w-1:0] ary;
	logic             xy;
	logic [dim_w-1:0] wcalc;
	logic [dim_w-1:0] hcalc;
	logic [dim_w-1:0] videow;
	logic [dim_w-1:0] videoh;
	logic [dim_w-1:0] h_off;
	logic [dim_w-1:0] v_off;
	logic [2:0]       step;
	logic             md_start;
	logic             md_busy;
	logic [dim_w-1:0] md_mul1;
	logic [dim_w-1:0] md_mul2;
	logic [dim_w-1:0] md_div;
	logic [dim_w-1:0] md_res;

	// Centering offsets against the full timing size
	assign h_off = (i_width - videow) >> 1;
	assign v_off = (i_height - videoh) >> 1;

	ar_muldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	// Output size limits and aspect selection
	always_ff @(posedge clk_sys) begin
		hdmi_width  <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
		hdmi_height <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

		if (i_ary == '0) begin
			if (i_arx == ar_w'(1)) begin
				arx <= i_arc1x[dim_w-1:0];
				ary <= i_arc1y[dim_w-1:0];
				xy  <= i_arc1x[ar_w-1] | i_arc1y[ar_w-1];
			end else if (i_arx == ar_w'(2)) begin
				arx <= i_arc2x[dim_w-1:0];
				ary <= i_arc2y[dim_w-1:0];
				xy  <= i_arc2x[ar_w-1] | i_arc2y[ar_w-1];
			end else begin
				arx <= '0;
				ary <= '0;
				xy  <= 1'b0;
			end
		end else begin
			arx <= i_arx[dim_w-1:0];
			ary <= i_ary[dim_w-1:0];
			xy  <= i_arx[ar_w-1] | i_ary[ar_w-1];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Step loop, runs continuously

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			step     <= '0;
			md_start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			md_start <= 1'b0;
			step     <= step + 1'b1;
			case (step)
				3'd0: begin
					if (i_freescale || arx == '0 || ary == '0) begin
						wcalc <= hdmi_width;
						hcalc <= hdmi_height;
						step  <= 3'd6;
					end else if (xy) begin
						// Direct size
						wcalc <= arx;
						hcalc <= ary;
						step  <= 3'd6;
					end
				end
				3'd1: begin
					md_mul1  <= hdmi_height;
					md_mul2  <= arx;
					md_div   <= ary;
					md_start <= 1'b1;
				end
				3'd2: begin
					wcalc <= md_res;
					if (md_start || md_busy)
						step <= 3'd2;
				end
				3'd3: begin
					md_mul1  <= hdmi_width;
					md_mul2  <= ary;
					md_div   <= arx;
					md_start <= 1'b1;
				end
				3'd4: begin
					hcalc <= md_res;
					if (md_start || md_busy)
						step <= 3'd4;
				end
				3'd6: begin
					// Clamp to output limits
					videow <= (wcalc > hdmi_width) ? hdmi_width : wcalc;
					videoh <= (hcalc > hdmi_height) ? hdmi_height : hcalc;
				end
				3'd7: begin
					o_hmin <= h_off;
					o_hmax <= h_off + videow - 1'b1;
					o_vmin <= v_off;
					o_vmax <= v_off + videoh - 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: sync_polarity_fix.sv
`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int sync_cnt_w = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic                  pol;
	logic [sync_cnt_w-1:0] cnt;
	logic [sync_cnt_w-1:0] len_hi;
	logic [sync_cnt_w-1:0] len_lo;

	// Active-high out whatever the input polarity
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			len_hi <= '0;
			len_lo <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Phase lengths latched at each edge
			if (~s2 & s1)
				len_lo <= cnt;
			if (s2 & ~s1)
				len_hi <= cnt;

			if (s2 != s1)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;

			// Longer high phase means the pulse is low
			pol <= len_hi > len_lo;
		end
	end

endmodule

// File: hps_video_top.sv
`timescale 1ns/1ps

module hps_video_top import hps_pkg::*; #(
	parameter int sync_cnt_w = 16
) (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_io_uio,
	input  logic             i_io_clk,
	input  logic [io_w-1:0]  i_io_din,
	input  logic [ar_w-1:0]  i_arx,
	input  logic [ar_w-1:0]  i_ary,
	input  logic [led_w-1:0] i_led_status,
	input  logic             i_hs_raw,
	output logic [led_w-1:0] o_led,
	output logic [dim_w-1:0] o_hmin,
	output logic [dim_w-1:0] o_hmax,
	output logic [dim_w-1:0] o_vmin,
	output logic [dim_w-1:0] o_vmax,
	output logic             o_hs_fixed
);

	logic [dim_w-1:0] width;
	logic [dim_w-1:0] height;
	logic [dim_w-1:0] vset;
	logic [dim_w-1:0] hset;
	logic             freescale;
	logic [ar_w-1:0]  arc1x;
	logic [ar_w-1:0]  arc1y;
	logic [ar_w-1:0]  arc2x;
	logic [ar_w-1:0]  arc2y;

	////////////////////////////////////////////////////////////////////////////
	// Host command port

	hps_cmd_decoder u_cmd_decoder (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_clk     (i_io_clk),
		.i_io_din     (i_io_din),
		.i_led_status (i_led_status),
		.o_led        (o_led),
		.o_width      (width),
		.o_height     (height),
		.o_vset       (vset),
		.o_hset       (hset),
		.o_freescale  (freescale),
		.o_arc1x      (arc1x),
		.o_arc1y      (arc1y),
		.o_arc2x      (arc2x),
		.o_arc2y      (arc2y)
	);

	////////////////////////////////////////////////////////////////////////////
	// Display window

	video_window_calc u_window_calc (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_width     (width),
		.i_height    (height),
		.i_vset      (vset),
		.i_hset      (hset),
		.i_freescale (freescale),
		.i_arx       (i_arx),
		.i_ary       (i_ary),
		.i_arc1x     (arc1x),
		.i_arc1y     (arc1y),
		.i_arc2x     (arc2x),
		.i_arc2y     (arc2y),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax)
	);

	// Horizontal sync made active-high
	sync_polarity_fix #(
		.sync_cnt_w (sync_cnt_w)
	) u_hs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_raw),
		.o_sync  (o_hs_fixed)
	);

endmodule

// File: tb_hps_video.sv
`timescale 1ns/1ps

module tb_hps_video;
	import hps_pkg::*;

	logic             clk_sys;
	logic             resetd;
	logic             i_io_uio;
	logic             i_io_clk;
	logic [io_w-1:0]  i_io_din;
	logic [ar_w-1:0]  i_arx;
	logic [ar_w-1:0]  i_ary;
	logic [led_w-1:0] i_led_status;
	logic             i_hs_raw;
	logic [led_w-1:0] o_led;
	logic [dim_w-1:0] o_hmin;
	logic [dim_w-1:0] o_hmax;
	logic [dim_w-1:0] o_vmin;
	logic [dim_w-1:0] o_vmax;
	logic             o_hs_fixed;

	// Data words of the next command
	logic [io_w-1:0]  cmd_words [0:7];

	int               errors;
	int               tests_run;
	int               tests_failed;
	int               err_mark;
	logic [led_w-1:0] led_stat;

	hps_video_top #(
		.sync_cnt_w (16)
	) u_dut (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_clk     (i_io_clk),
		.i_io_din     (i_io_din),
		.i_arx        (i_arx),
		.i_ary        (i_ary),
		.i_led_status (i_led_status),
		.i_hs_raw     (i_hs_raw),
		.o_led        (o_led),
		.o_hmin       (o_hmin),
		.o_hmax       (o_hmax),
		.o_vmin       (o_vmin),
		.o_vmax       (o_vmax),
		.o_hs_fixed   (o_hs_fixed)
	);

	always #20 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Checking and reporting

	task automatic check_value(input string name, input int exp, input int got);
		assert (got == exp) else begin
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic close_test(input string name, input int err_at_start);
		tests_run++;
		if (errors == err_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED", name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host port

	// Strobe high for 2 cycles and low for 2 cycles
	task automatic send_word(input logic [io_w-1:0] w);
		@(posedge clk_sys);
		i_io_din <= w;
		i_io_clk <= 1'b1;
		repeat (2) @(posedge clk_sys);
		i_io_clk <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic send_cmd(input cmd_e op, input int n_words);
		int i;
		@(posedge clk_sys);
		i_io_uio <= 1'b1;
		send_word({8'h00, op});
		for (i = 0; i < n_words; i++)
			send_word(cmd_words[i]);
		@(posedge clk_sys);
		i_io_uio <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Poll until the window matches, then confirm it holds
	task automatic wait_window(input int exp_hmin, input int exp_hmax,
		input int exp_vmin, input int exp_vmax);
		int n;
		bit hit;
		hit = 1'b0;
		for (n = 0; n < 200 && !hit; n++) begin
			@(negedge clk_sys);
			hit = (int'(o_hmin) == exp_hmin) && (int'(o_hmax) == exp_hmax) &&
				(int'(o_vmin) == exp_vmin) && (int'(o_vmax) == exp_vmax);
		end
		assert (hit) else begin
			$display("timeout at t=%0t: display window never reached the expected edges",
				$time);
			errors++;
		end
		for (n = 0; n < 60; n++)
			@(negedge clk_sys);
		check_value("o_hmin", exp_hmin, int'(o_hmin));
		check_value("o_hmax", exp_hmax, int'(o_hmax));
		check_value("o_vmin", exp_vmin, int'(o_vmin));
		check_value("o_vmax", exp_vmax, int'(o_vmax));
	endtask

	// One sync period of 4 low and 36 high cycles
	task automatic run_hs_period(input bit check);
		int c;
		for (c = 0; c < 40; c++) begin
			@(posedge clk_sys);
			i_hs_raw <= (c >= 4);
			@(negedge clk_sys);
			if (check)
				check_value("o_hs_fixed", (c < 4) ? 1 : 0, int'(o_hs_fixed));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		clk_sys      = 1'b0;
		resetd       = 1'b1;
		i_io_uio     = 1'b0;
		i_io_clk     = 1'b0;
		i_io_din     = '0;
		i_arx        = '0;
		i_ary        = '0;
		i_led_status = '0;
		i_hs_raw     = 1'b1;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(49119));

		repeat (2) @(posedge clk_sys);
		resetd <= 1'b0;

		err_mark = errors;
		wait_window(0, 1919, 0, 1079);
		close_test("full screen at reset", err_mark);

		// 4:3 pillarbox on 1920x1080
		err_mark = errors;
		@(posedge clk_sys);
		i_arx <= 13'd4;
		i_ary <= 13'd3;
		wait_window(240, 1679, 0, 1079);
		close_test("aspect 4:3", err_mark);

		// Width in word 0, height in word 4
		err_mark = errors;
		cmd_words[0] = 16'd1280;
		cmd_words[1] = 16'd0;
		cmd_words[2] = 16'd0;
		cmd_words[3] = 16'd0;
		cmd_words[4] = 16'd1024;
		send_cmd(cmd_video_timing, 5);
		wait_window(0, 1279, 32, 991);
		close_test("video timing command", err_mark);

		err_mark = errors;
		cmd_words[0] = 16'd1920;
		cmd_words[4] = 16'd1080;
		send_cmd(cmd_video_timing, 5);
		cmd_words[0] = 16'h8000 | 16'd1280;
		send_cmd(cmd_hset, 1);
		wait_window(320, 1599, 0, 1079);
		close_test("hset with free scale", err_mark);

		// Direct size 800x600 through arc1
		err_mark = errors;
		cmd_words[0] = 16'd0;
		send_cmd(cmd_hset, 1);
		cmd_words[0] = 16'h1000 | 16'd800;
		cmd_words[1] = 16'd600;
		send_cmd(cmd_custom_ar, 2);
		@(posedge clk_sys);
		i_arx <= 13'd1;
		i_ary <= 13'd0;
		wait_window(560, 1359, 240, 839);
		close_test("custom aspect", err_mark);

		err_mark = errors;
		led_stat = 8'($urandom);
		@(posedge clk_sys);
		i_led_status <= led_stat;
		@(negedge clk_sys);
		check_value("o_led", int'(led_stat), int'(o_led));
		cmd_words[0] = 16'hF0A5;
		send_cmd(cmd_led, 1);
		led_stat = 8'($urandom);
		@(posedge clk_sys);
		i_led_status <= led_stat;
		@(negedge clk_sys);
		check_value("o_led", int'({4'hA, led_stat[3:0]}), int'(o_led));
		// Polarity settles over the first periods
		repeat (3) run_hs_period(1'b0);
		run_hs_period(1'b1);
		close_test("led override and sync polarity", err_mark);

		$display("summary: %0d tests, %0d failing, %0d errors",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Overall limit on the run
	initial begin
		repeat (20000) @(posedge clk_sys);
		$display("run limit reached before the sequence finished");
		$display("tests failed");
		$finish;
	end

endmodule

// File: project.f
hps_pkg.sv
hps_cmd_decoder.sv
ar_muldiv.sv
video_window_calc.sv
sync_polarity_fix.sv
hps_video_top.sv
tb_hps_video.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_hps_video -f project.f

./obj_dir/Vtb_hps_video | tee sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0
